//--- Makefile
# Verilator build and run of the multiplier testbench

VERILATOR ?= verilator
TOP ?= tbMultiplier
FILELIST ?= filelist.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_TEXT ?= Done: no errors
VFLAGS ?= --binary --timing --assert -Wno-fatal --timescale 1ns/100ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- filelist.f
+incdir+.
mulPkg.sv
pipeReg.sv
ppCompress.sv
rowMerge.sv
mulPipeline.sv
resultFifo.sv
multiplierTop.sv
mul_props.sv
tbMultiplier.sv

//--- mulPipeline.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// multiplier pipeline
// compress, merge and final add behind three
// handshaked stage registers
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module mulPipeline (
	input logic clk,
	input logic reset,
	input logic inValid,
	output logic inReady,
	input mulPkg::operandPairT inOperands,
	output logic outValid,
	input logic outReady,
	output mulPkg::productT outProduct
);

	import mulPkg::*;

	groupSumsT groupSumsIn;
	groupSumsT groupSumsReg;
	carrySaveT mergedIn;
	carrySaveT mergedReg;
	productT finalSum;
	logic groupValid;
	logic groupReady;
	logic mergeValid;
	logic mergeReady;

	// stage 1: array and first 3:2 level
	ppCompress ppCompress_inst (
		.operands(inOperands),
		.groupSums(groupSumsIn)
	);

	pipeReg #(.payloadT(groupSumsT)) groupReg_inst (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inReady(inReady),
		.inData(groupSumsIn),
		.outValid(groupValid),
		.outReady(groupReady),
		.outData(groupSumsReg)
	);

	// stage 2: weighted group sums down to two rows
	rowMerge rowMerge_inst (
		.groupSums(groupSumsReg),
		.merged(mergedIn)
	);

	pipeReg #(.payloadT(carrySaveT)) mergeReg_inst (
		.clk(clk),
		.reset(reset),
		.inValid(groupValid),
		.inReady(groupReady),
		.inData(mergedIn),
		.outValid(mergeValid),
		.outReady(mergeReady),
		.outData(mergedReg)
	);

	// stage 3: carry-propagate add, wraps modulo 2^(2*width)
	assign finalSum = mergedReg.sumRow + mergedReg.carryRow;

	pipeReg #(.payloadT(productT)) productReg_inst (
		.clk(clk),
		.reset(reset),
		.inValid(mergeValid),
		.inReady(mergeReady),
		.inData(finalSum),
		.outValid(outValid),
		.outReady(outReady),
		.outData(outProduct)
	);

endmodule

`default_nettype wire

//--- mulPkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// multiplier types
// operand pair, pipeline stage payloads and the
// full-width signed product
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "mul_macros.svh"

package mulPkg;

	// three-row groups in the partial-product array
	localparam int groupCount = `MUL_WIDTH / `CSA_GROUP;

	// both operands of one multiply, two's complement
	typedef struct packed {
		logic signed [`MUL_WIDTH-1:0] multiplicand;
		logic signed [`MUL_WIDTH-1:0] multiplier;
	} operandPairT;

	// full product, never truncated
	typedef logic signed [2*`MUL_WIDTH-1:0] productT;

	// first stage payload
	// one row sum per group, each at its own group weight
	// three extra bits cover the x1, x2, x4 row weights plus the carry
	typedef struct packed {
		logic [groupCount-1:0][`MUL_WIDTH+2:0] rowSum;
	} groupSumsT;

	// second stage payload
	// redundant form, the product is sumRow + carryRow modulo 2^(2*width)
	typedef struct packed {
		logic [2*`MUL_WIDTH-1:0] sumRow;
		logic [2*`MUL_WIDTH-1:0] carryRow;
	} carrySaveT;

endpackage

`default_nettype wire

//--- mul_macros.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// multiplier build constants
// operand width, row grouping and result buffering
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef MUL_MACROS_SVH
`define MUL_MACROS_SVH

// operand width in bits
// rows are grouped in threes twice, so keep it a multiple of 9
`define MUL_WIDTH 18

// rows combined by one 3:2 compression
`define CSA_GROUP 3

// entries in the result FIFO, the presented head included
`define RESULT_FIFO_DEPTH 4

`endif

//--- mul_props.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// multiplier handshake properties
// output hold, reset state and FIFO occupancy
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "mul_macros.svh"

module mulProps (
	input logic clk,
	input logic reset,
	input logic outValid,
	input logic outReady,
	input mulPkg::productT outProduct,
	input logic pipeValid,
	input logic pipeReady
);

	timeunit 1ns;
	timeprecision 100ps;

	// results inside the FIFO, tracked from its two handshakes
	int fifoLevel;

	always_ff @(posedge clk) begin
		if (reset) begin
			fifoLevel <= 0;
		end else begin
			fifoLevel <= fifoLevel + int'(pipeValid && pipeReady) - int'(outValid && outReady);
		end
	end

	// a stalled product stays presented and unchanged
	holdStable: assert property (@(posedge clk) disable iff (reset)
		(outValid && !outReady) |=> (outValid && $stable(outProduct)))
		else $error("outProduct changed or outValid dropped while stalled");

	// nothing presented right after reset
	resetIdle: assert property (@(posedge clk) reset |=> !outValid)
		else $error("outValid high in the cycle after reset");

	levelBound: assert property (@(posedge clk) disable iff (reset)
		fifoLevel <= `RESULT_FIFO_DEPTH)
		else $error("FIFO holds %0d results, more than its depth", fifoLevel);

endmodule

bind multiplierTop mulProps mulProps_inst (
	.clk(clk),
	.reset(reset),
	.outValid(outValid),
	.outReady(outReady),
	.outProduct(outProduct),
	.pipeValid(pipeValid),
	.pipeReady(pipeReady)
);

`default_nettype wire

//--- multiplierTop.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pipelined signed multiplier top
// multiplier pipeline into the result FIFO
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module multiplierTop (
	input logic clk,
	input logic reset,
	input logic inValid,
	output logic inReady,
	input mulPkg::operandPairT inOperands,
	output logic outValid,
	input logic outReady,
	output mulPkg::productT outProduct
);

	import mulPkg::*;

	// last pipeline stage to FIFO
	productT pipeProduct;
	logic pipeValid;
	logic pipeReady;

	mulPipeline mulPipeline_inst (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inReady(inReady),
		.inOperands(inOperands),
		.outValid(pipeValid),
		.outReady(pipeReady),
		.outProduct(pipeProduct)
	);

	// absorbs results while the consumer holds outReady low
	resultFifo #(.payloadT(productT)) resultFifo_inst (
		.clk(clk),
		.reset(reset),
		.inValid(pipeValid),
		.inReady(pipeReady),
		.inData(pipeProduct),
		.outValid(outValid),
		.outReady(outReady),
		.outData(outProduct)
	);

endmodule

`default_nettype wire

//--- pipeReg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pipeline stage register
// one item deep, valid/ready on both sides
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module pipeReg #(
	parameter type payloadT = mulPkg::productT
) (
	input logic clk,
	input logic reset,
	input logic inValid,
	output logic inReady,
	input payloadT inData,
	output logic outValid,
	input logic outReady,
	output payloadT outData
);

	logic loadEn;

	// free when empty or when the held item leaves this cycle
	// a stall downstream ripples back through this term
	assign inReady = !outValid || outReady;
	assign loadEn = inValid && inReady;

	always_ff @(posedge clk) begin
		if (reset) begin
			outValid <= 1'b0;
		end else if (inReady) begin
			// empties itself when nothing new arrives
			outValid <= inValid;
		end
	end

	// payload only moves on an accepted transfer
	always_ff @(posedge clk) begin
		if (loadEn) begin
			outData <= inData;
		end
	end

endmodule

`default_nettype wire

//--- ppCompress.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// partial-product array and first compression
// Baugh-Wooley rows, 3:2 per group of three rows,
// then one row sum per group
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "mul_macros.svh"

module ppCompress (
	input mulPkg::operandPairT operands,
	output mulPkg::groupSumsT groupSums
);

	import mulPkg::*;

	localparam int width = `MUL_WIDTH;

	// row r has weight 2^r and is gated by multiplicand bit r
	logic [width-1:0] ppRows [width];

	always_comb begin
		for (int r = 0; r < width; r++) begin
			ppRows[r][width-2:0] = {(width-1){operands.multiplicand[r]}}
				& operands.multiplier[width-2:0];
			// sign column term goes in inverted
			ppRows[r][width-1] = ~(operands.multiplicand[r] & operands.multiplier[width-1]);
		end
		// last row: sign times sign stays true, its low terms are inverted instead
		ppRows[width-1][width-1] = operands.multiplicand[width-1] & operands.multiplier[width-1];
		ppRows[width-1][width-2:0] = ~ppRows[width-1][width-2:0];
	end

	for (genvar g = 0; g < groupCount; g++) begin : rowGroup
		localparam int base = `CSA_GROUP * g;
		// correction one at weight 2^width, only group zero has room for it
		localparam logic leadOne = (g == 0);

		logic [width-1:0] a;
		logic [width-1:0] b;
		logic [width-1:0] c;
		logic [width+1:0] partSum;
		logic [width-1:0] partCarry;

		// align the three rows on weight base+1
		// LSB of the first row and MSB of the third cannot carry
		assign a = {leadOne, ppRows[base][width-1:1]};
		assign b = ppRows[base+1];
		assign c = {ppRows[base+2][width-2:0], 1'b0};

		assign partSum[0] = ppRows[base][0];
		assign partSum[width:1] = a ^ b ^ c;
		assign partSum[width+1] = ppRows[base+2][width-1];
		// carry bit k sits at weight k+2
		assign partCarry = (a & b) | (a & c) | (b & c);

		// two low bits pass straight, the rest resolves with one extra carry bit
		assign groupSums.rowSum[g] = {
			{1'b0, partSum[width+1:2]} + {1'b0, partCarry},
			partSum[1:0]
		};
	end

endmodule

`default_nettype wire

//--- resultFifo.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// result FIFO
// circular buffer with a registered head output
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "mul_macros.svh"

module resultFifo #(
	parameter type payloadT = mulPkg::productT
) (
	input logic clk,
	input logic reset,
	input logic inValid,
	output logic inReady,
	input payloadT inData,
	output logic outValid,
	input logic outReady,
	output payloadT outData
);

	localparam int depth = `RESULT_FIFO_DEPTH;
	localparam int ptrWidth = (depth > 1) ? $clog2(depth) : 1;
	localparam int countWidth = $clog2(depth + 1);

	payloadT mem [depth];
	logic [ptrWidth-1:0] wrPtr;
	logic [ptrWidth-1:0] rdPtr;
	logic [ptrWidth-1:0] loadAddr;
	// entries held, the one on the output included
	logic [countWidth-1:0] count;
	logic push;
	logic pop;
	logic loadOut;

	function automatic logic [ptrWidth-1:0] nextPtr(input logic [ptrWidth-1:0] ptr);
		return (ptr == ptrWidth'(depth - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign pop = outValid && outReady;
	// a full buffer still takes a write while its head leaves
	assign inReady = (count != countWidth'(depth)) || pop;
	assign push = inValid && inReady;

	// head leaving: fetch the entry behind it if there is one
	// idle output: fetch the head once it is in storage
	assign loadAddr = pop ? nextPtr(rdPtr) : rdPtr;
	assign loadOut = pop ? (count > countWidth'(1)) : (!outValid && count != '0);

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wrPtr] <= inData;
		end
		if (loadOut) begin
			outData <= mem[loadAddr];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			outValid <= 1'b0;
		end else begin
			if (push) begin
				wrPtr <= nextPtr(wrPtr);
			end
			if (pop) begin
				rdPtr <= nextPtr(rdPtr);
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			if (!outValid || pop) begin
				outValid <= loadOut;
			end
		end
	end

endmodule

`default_nettype wire

//--- rowMerge.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// second carry-save level
// folds the weighted group sums to a sum row and
// a carry row
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "mul_macros.svh"

module rowMerge (
	input mulPkg::groupSumsT groupSums,
	output mulPkg::carrySaveT merged
);

	import mulPkg::*;

	localparam int prodWidth = 2 * `MUL_WIDTH;
	localparam int tripleCount = groupCount / `CSA_GROUP;
	// second leading one of the array, at the product MSB
	localparam logic [prodWidth-1:0] correction = {1'b1, {(prodWidth-1){1'b0}}};

	// each group sum at its weight, three bits per group
	logic [prodWidth-1:0] placed [groupCount];

	// 3:2 at full product width, carries past the MSB fall off
	function automatic carrySaveT csa(
		input logic [prodWidth-1:0] a,
		input logic [prodWidth-1:0] b,
		input logic [prodWidth-1:0] c
	);
		carrySaveT res;
		res.sumRow = a ^ b ^ c;
		res.carryRow = ((a & b) | (a & c) | (b & c)) << 1;
		return res;
	endfunction

	always_comb begin
		for (int g = 0; g < groupCount; g++) begin
			placed[g] = prodWidth'(groupSums.rowSum[g]) << (`CSA_GROUP * g);
		end
	end

	always_comb begin
		carrySaveT acc;
		// first triple starts the accumulator
		acc = csa(placed[0], placed[1], placed[2]);
		// every further triple compresses to two rows and folds in one at a time
		for (int t = 1; t < tripleCount; t++) begin : tripleFold
			carrySaveT part;
			part = csa(placed[`CSA_GROUP*t], placed[`CSA_GROUP*t+1], placed[`CSA_GROUP*t+2]);
			acc = csa(acc.sumRow, acc.carryRow, part.sumRow);
			acc = csa(acc.sumRow, acc.carryRow, part.carryRow);
		end
		merged.sumRow = acc.sumRow;
		// adding the MSB one modulo 2^prodWidth is a flip of that bit
		merged.carryRow = acc.carryRow ^ correction;
	end

endmodule

`default_nettype wire

//--- tbMultiplier.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// multiplier testbench
// table-driven operands, scoreboard against the
// exact signed product, stall and timing checks
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "mul_macros.svh"

module tbMultiplier;

	timeunit 1ns;
	timeprecision 100ps;

	import mulPkg::*;

	localparam int width = `MUL_WIDTH;
	localparam int entryCount = 30;
	// three stage registers plus the FIFO entries
	localparam int stallDepth = 3 + `RESULT_FIFO_DEPTH;
	localparam int pipeLatency = 4;
	localparam int cycleLimit = 20 * (entryCount + 4);
	localparam int readyHigh = 0;
	localparam int readyLow = 1;
	localparam int readyTable = 2;

	typedef struct packed {
		logic signed [width-1:0] multiplicand;
		logic signed [width-1:0] multiplier;
		logic readyBit;
	} stimT;

	typedef struct packed {
		productT product;
		logic timed;
		logic [31:0] acceptCycle;
	} expectT;

	logic clk;
	logic reset;
	logic inValid;
	logic inReady;
	operandPairT inOperands;
	logic outValid;
	logic outReady;
	productT outProduct;

	stimT stimTable [entryCount];
	expectT expectQ [$];
	int cycleCount = 0;
	int mismatchCount = 0;
	int protocolCount = 0;
	int timeoutCount = 0;
	int readyMode = readyHigh;
	logic timedPass = 1'b0;

	multiplierTop multiplierTop_inst (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inReady(inReady),
		.inOperands(inOperands),
		.outValid(outValid),
		.outReady(outReady),
		.outProduct(outProduct)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycleCount++;
	end

	// exact product, both operands sign-extended to full width first
	function automatic productT expectedProduct(input logic signed [width-1:0] a,
			input logic signed [width-1:0] b);
		productT wideA;
		productT wideB;
		wideA = a;
		wideB = b;
		return wideA * wideB;
	endfunction

	function automatic logic readyFor();
		if (readyMode == readyHigh) begin
			return 1'b1;
		end else if (readyMode == readyLow) begin
			return 1'b0;
		end
		// walks the table bits, one per cycle
		return stimTable[cycleCount % entryCount].readyBit;
	endfunction

	task automatic fillTable();
		logic signed [width-1:0] maxPos;
		logic signed [width-1:0] minNeg;
		maxPos = {1'b0, {(width-1){1'b1}}};
		minNeg = {1'b1, {(width-1){1'b0}}};
		stimTable[0] = '{'0, '0, 1'b1};
		stimTable[1] = '{1, -1, 1'b1};
		stimTable[2] = '{maxPos, maxPos, 1'b0};
		stimTable[3] = '{minNeg, minNeg, 1'b1};
		stimTable[4] = '{minNeg, maxPos, 1'b0};
		stimTable[5] = '{-1, -1, 1'b1};
		for (int i = 6; i < entryCount; i++) begin
			stimTable[i].multiplicand = width'($urandom);
			stimTable[i].multiplier = width'($urandom);
			stimTable[i].readyBit = 1'($urandom % 2);
		end
	endtask

	// holds the pair until accepted, starts and ends just after a rising edge
	task automatic applyEntry(input int idx, output int waitCycles);
		expectT item;
		logic accepted;
		accepted = 1'b0;
		waitCycles = 0;
		inOperands.multiplicand = stimTable[idx].multiplicand;
		inOperands.multiplier = stimTable[idx].multiplier;
		inValid = 1'b1;
		while (!accepted) begin
			outReady = readyFor();
			@(negedge clk);
			if (inReady) begin
				accepted = 1'b1;
				item.product = expectedProduct(stimTable[idx].multiplicand,
					stimTable[idx].multiplier);
				item.timed = timedPass;
				// the transfer itself happens on the coming rising edge
				item.acceptCycle = cycleCount + 1;
				expectQ.push_back(item);
			end else begin
				waitCycles++;
			end
			@(posedge clk);
			#1;
		end
	endtask

	task automatic drainResults();
		while (expectQ.size() != 0) begin
			outReady = readyFor();
			@(posedge clk);
			#1;
		end
	endtask

	task automatic finishRun();
		int total;
		total = mismatchCount + protocolCount + timeoutCount;
		$display("errors: %0d (value %0d, protocol %0d, timeout %0d)",
			total, mismatchCount, protocolCount, timeoutCount);
		if (total == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	endtask

	// scoreboard, sampled mid-cycle where every handshake signal is settled
	always @(negedge clk) begin
		expectT exp;
		if (!reset && outValid) begin
			assert (expectQ.size() != 0) else begin
				$display("output valid with no product outstanding");
				protocolCount++;
			end
		end
		if (!reset && outValid && outReady && expectQ.size() != 0) begin
			exp = expectQ.pop_front();
			assert (outProduct == exp.product) else begin
				$display("CHECK FAILED outProduct expected %h got %h", exp.product, outProduct);
				mismatchCount++;
			end
			if (exp.timed) begin
				assert (cycleCount - int'(exp.acceptCycle) == pipeLatency) else begin
					$display("CHECK FAILED latency expected %h got %h", pipeLatency,
						cycleCount - int'(exp.acceptCycle));
					mismatchCount++;
				end
			end
		end
	end

	initial begin
		wait (cycleCount >= cycleLimit);
		timeoutCount++;
		$display("timeout after %0d cycles, %0d products missing", cycleCount, expectQ.size());
		finishRun();
	end

	initial begin
		int waits;
		void'($urandom(32'h57ad));
		reset = 1'b1;
		inValid = 1'b0;
		inOperands = '0;
		outReady = 1'b0;
		fillTable();
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
		@(negedge clk);
		assert (inReady) else begin
			$display("inReady low after reset");
			protocolCount++;
		end
		@(posedge clk);
		#1;

		// back to back with a free output, every product exactly 4 cycles late
		readyMode = readyHigh;
		timedPass = 1'b1;
		for (int i = 0; i < entryCount; i++) begin
			applyEntry(i, waits);
			assert (waits == 0) else begin
				$display("pair %0d stalled with the output free", i);
				protocolCount++;
			end
		end
		inValid = 1'b0;
		timedPass = 1'b0;
		drainResults();

		// output blocked, pipeline and FIFO take exactly stallDepth pairs
		readyMode = readyLow;
		for (int i = 0; i < stallDepth; i++) begin
			applyEntry(i, waits);
			assert (waits == 0) else begin
				$display("pair %0d held back before the pipeline was full", i);
				protocolCount++;
			end
		end
		inOperands.multiplicand = stimTable[stallDepth].multiplicand;
		inOperands.multiplier = stimTable[stallDepth].multiplier;
		inValid = 1'b1;
		repeat (3) begin
			@(negedge clk);
			assert (!inReady) else begin
				$display("inReady still high with the pipeline and FIFO full");
				protocolCount++;
			end
			@(posedge clk);
			#1;
		end
		readyMode = readyHigh;
		for (int i = stallDepth; i < entryCount; i++) begin
			applyEntry(i, waits);
		end
		inValid = 1'b0;
		drainResults();

		// output ready follows the table bits
		readyMode = readyTable;
		for (int i = 0; i < entryCount; i++) begin
			applyEntry(i, waits);
		end
		inValid = 1'b0;
		drainResults();
		finishRun();
	end

endmodule

`default_nettype wire
